//--- Bender.yml
package:
  name: spec_check

sources:
  - include_dirs:
      - include
    files:
      - source/spec_pkg.sv
      - source/retire_if.sv
      - source/retire_capture.sv
      - source/retire_fifo.sv
      - source/spec_step.sv
      - source/spec_check_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/spec_check_properties.sv
      - test/spec_check_tb.sv

//--- compile.f
+incdir+include
source/spec_pkg.sv
source/retire_if.sv
source/retire_capture.sv
source/retire_fifo.sv
source/spec_step.sv
source/spec_check_top.sv
test/spec_check_properties.sv
test/spec_check_tb.sv

//--- include/spec_check_macros.svh
// Shared constants for the retirement checker.
// Include this file wherever the FIFO depth or the RV32 encodings are needed.

`ifndef SPEC_CHECK_MACROS_SVH
`define SPEC_CHECK_MACROS_SVH

// number of retire records the FIFO can hold, a power of two.
`define SPEC_FIFO_DEPTH 4

// major opcodes of the supported subset.
`define SPEC_OP_IMM   7'b0010011
`define SPEC_OP_REG   7'b0110011
`define SPEC_OP_LUI   7'b0110111
`define SPEC_OP_STORE 7'b0100011

// funct3 values for ADD/ADDI and for word stores.
`define SPEC_F3_ADD 3'b000
`define SPEC_F3_SW  3'b010

`endif

//--- source/retire_capture.sv
// Registers the core's retirement report into a single push on retire_if.
// Decouples the checker from the timing of the core's retire ports.

module retire_capture (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              retire_valid_i,
    input  logic [31:0]       retire_insn_i,
    input  logic [31:0]       retire_pc_i,
    input  logic [31:0]       retire_rs1_i,
    input  logic [31:0]       retire_rs2_i,
    input  logic [31:0]       retire_rd_wdata_i,
    input  logic              retire_rd_we_i,
    retire_if.producer        rec_o
);

    // push is high for exactly one cycle per strobe.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rec_o.push <= 1'b0;
        end else begin
            rec_o.push <= retire_valid_i;
        end
    end

    // fields are only loaded when a report is present.
    always_ff @(posedge clk_i) begin
        if (retire_valid_i) begin
            rec_o.insn     <= retire_insn_i;
            rec_o.pc       <= retire_pc_i;
            rec_o.rs1_val  <= retire_rs1_i;
            rec_o.rs2_val  <= retire_rs2_i;
            rec_o.rd_wdata <= retire_rd_wdata_i;
            rec_o.rd_we    <= retire_rd_we_i;
        end
    end

endmodule

//--- source/retire_fifo.sv
// Circular buffer of retire records between capture and the spec step.
// The read side presents the oldest record while not empty and drops it
// on pop. A push into a full buffer without a pop is lost and flagged.

`include "spec_check_macros.svh"

module retire_fifo (
    input  logic                  clk_i,
    input  logic                  rst_i,
    retire_if.buffer              rec_i,
    input  logic                  pop_i,
    output spec_pkg::retire_rec_t rec_o,
    output logic                  empty_o,
    output logic                  overflow_o
);

    localparam int unsigned fifo_depth = `SPEC_FIFO_DEPTH;
    localparam int unsigned ptr_w      = $clog2(fifo_depth);

    // the extra top bit tells full from empty when the indices match.
    logic [ptr_w:0]        wr_ptr_q;
    logic [ptr_w:0]        rd_ptr_q;
    spec_pkg::retire_rec_t mem_q [fifo_depth];
    spec_pkg::retire_rec_t push_rec;
    logic                  full;
    logic                  do_push;
    logic                  do_pop;

    assign push_rec = '{
        insn:     rec_i.insn,
        pc:       rec_i.pc,
        rs1_val:  rec_i.rs1_val,
        rs2_val:  rec_i.rs2_val,
        rd_wdata: rec_i.rd_wdata,
        rd_we:    rec_i.rd_we
    };

    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full    = (wr_ptr_q[ptr_w] != rd_ptr_q[ptr_w]) &&
                     (wr_ptr_q[ptr_w-1:0] == rd_ptr_q[ptr_w-1:0]);

    assign do_pop  = pop_i && !empty_o;
    assign do_push = rec_i.push && (!full || do_pop);  // a pop frees the slot this cycle.

    assign rec_o = mem_q[rd_ptr_q[ptr_w-1:0]];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            overflow_o <= rec_i.push && !do_push;
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q[ptr_w-1:0]] <= push_rec;
        end
    end

endmodule

//--- source/retire_if.sv
// Carries one captured retire record from the capture stage into the FIFO.
// The producer drives every field and a record is written on each edge
// where push is high.

interface retire_if;

    logic              push;
    spec_pkg::insn_u   insn;
    logic [31:0]       pc;
    logic [31:0]       rs1_val;
    logic [31:0]       rs2_val;
    logic [31:0]       rd_wdata;
    logic              rd_we;

    modport producer (
        output push,
        output insn,
        output pc,
        output rs1_val,
        output rs2_val,
        output rd_wdata,
        output rd_we
    );

    modport buffer (
        input push,
        input insn,
        input pc,
        input rs1_val,
        input rs2_val,
        input rd_wdata,
        input rd_we
    );

endinterface

//--- source/spec_check_top.sv
// Top level of the retirement checker.
// Connect the core's retire ports here. Results appear on the spec step
// outputs, check_valid_o marks the end of each record, and overflow_o
// reports records lost to a full FIFO.

module spec_check_top (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        retire_valid_i,
    input  logic [31:0] retire_insn_i,
    input  logic [31:0] retire_pc_i,
    input  logic [31:0] retire_rs1_i,
    input  logic [31:0] retire_rs2_i,
    input  logic [31:0] retire_rd_wdata_i,
    input  logic        retire_rd_we_i,
    output logic        wx_en_o,
    output logic [4:0]  wx_addr_o,
    output logic [31:0] wx_o,
    output logic        mem_write_o,
    output logic [31:0] mem_addr_o,
    output logic [31:0] mem_wdata_o,
    output logic [3:0]  mem_be_o,
    output logic        mem_snd_gran_o,
    output logic        check_valid_o,
    output logic        mismatch_o,
    output logic        int_err_o,
    output logic        overflow_o
);

    retire_if              cap_rec ();
    spec_pkg::retire_rec_t head_rec;
    logic                  fifo_empty;
    logic                  step_pop;

    retire_capture i_capture (
        .clk_i,
        .rst_i,
        .retire_valid_i,
        .retire_insn_i,
        .retire_pc_i,
        .retire_rs1_i,
        .retire_rs2_i,
        .retire_rd_wdata_i,
        .retire_rd_we_i,
        .rec_o             (cap_rec)
    );

    retire_fifo i_fifo (
        .clk_i,
        .rst_i,
        .rec_i      (cap_rec),
        .pop_i      (step_pop),
        .rec_o      (head_rec),
        .empty_o    (fifo_empty),
        .overflow_o
    );

    spec_step i_step (
        .clk_i,
        .rst_i,
        .rec_i          (head_rec),
        .empty_i        (fifo_empty),
        .pop_o          (step_pop),
        .wx_en_o,
        .wx_addr_o,
        .wx_o,
        .mem_write_o,
        .mem_addr_o,
        .mem_wdata_o,
        .mem_be_o,
        .mem_snd_gran_o,
        .check_valid_o,
        .mismatch_o,
        .int_err_o
    );

endmodule

//--- source/spec_pkg.sv
// Types shared by the retirement checker.
// Holds the two decode views of an instruction word and the retire record
// that travels from capture through the FIFO to the specification step.

package spec_pkg;

    // I-type layout, also used to pick rd and funct3 for every format.
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // S-type layout. The immediate is split around rs2 and rs1.
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    // one instruction word, decoded through whichever view the opcode selects.
    typedef union packed {
        i_type_t i_view;
        s_type_t s_view;
    } insn_u;

    // one retired instruction as reported by the core.
    typedef struct packed {
        insn_u       insn;
        logic [31:0] pc;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] rd_wdata;  // register write value the core claims.
        logic        rd_we;     // register write enable the core claims.
    } retire_rec_t;

endpackage

//--- source/spec_step.sv
// Reduced RV32 specification step for ADDI, ADD, LUI and SW.
// Pops one record when idle, registers the register write and the store
// granules under core-facing names, and compares against the core's claim.
// A misaligned store takes two cycles, one per granule.

`include "spec_check_macros.svh"

module spec_step (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  spec_pkg::retire_rec_t rec_i,
    input  logic                  empty_i,
    output logic                  pop_o,
    output logic                  wx_en_o,
    output logic [4:0]            wx_addr_o,
    output logic [31:0]           wx_o,
    output logic                  mem_write_o,
    output logic [31:0]           mem_addr_o,
    output logic [31:0]           mem_wdata_o,
    output logic [3:0]            mem_be_o,
    output logic                  mem_snd_gran_o,
    output logic                  check_valid_o,
    output logic                  mismatch_o,
    output logic                  int_err_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic        is_addi;
    logic        is_add;
    logic        is_lui;
    logic        is_sw;
    logic        supported;
    logic        misaligned;
    logic        spec_we;
    logic [31:0] spec_wdata;
    logic        reg_mismatch;
    logic [31:0] store_addr;
    logic [1:0]  k;
    logic [31:0] fst_addr;
    logic [3:0]  fst_be;
    logic [31:0] fst_wdata;
    logic [3:0]  snd_be;
    logic [31:0] snd_wdata;

    // second granule state, held across the extra cycle of a misaligned store.
    logic        snd_q;
    logic [31:0] snd_addr_q;
    logic [31:0] snd_wdata_q;
    logic [3:0]  snd_be_q;
    logic        snd_mismatch_q;

    assign opcode = rec_i.insn.i_view.opcode;
    assign funct3 = rec_i.insn.i_view.funct3;
    assign rd     = rec_i.insn.i_view.rd;

    assign imm_i = {{20{rec_i.insn.i_view.imm[11]}}, rec_i.insn.i_view.imm};
    assign imm_s = {{20{rec_i.insn.s_view.imm_hi[6]}},
                    rec_i.insn.s_view.imm_hi, rec_i.insn.s_view.imm_lo};

    assign is_addi = (opcode == `SPEC_OP_IMM) && (funct3 == `SPEC_F3_ADD);
    // funct7 occupies the top of the I immediate field.
    assign is_add  = (opcode == `SPEC_OP_REG) && (funct3 == `SPEC_F3_ADD) &&
                     (rec_i.insn.i_view.imm[11:5] == 7'd0);
    assign is_lui  = (opcode == `SPEC_OP_LUI);
    assign is_sw   = (opcode == `SPEC_OP_STORE) && (funct3 == `SPEC_F3_SW);
    assign supported = is_addi || is_add || is_lui || is_sw;

    always_comb begin
        spec_wdata = 32'd0;
        if (is_addi) begin
            spec_wdata = rec_i.rs1_val + imm_i;
        end else if (is_add) begin
            spec_wdata = rec_i.rs1_val + rec_i.rs2_val;
        end else if (is_lui) begin
            spec_wdata = {rec_i.insn[31:12], 12'd0};
        end
    end

    assign spec_we      = (is_addi || is_add || is_lui) && (rd != 5'd0);  // x0 is never written.
    assign reg_mismatch = (rec_i.rd_we != spec_we) ||
                          (spec_we && (rec_i.rd_wdata != spec_wdata));

    // store address split into a word address and a byte offset k.
    assign store_addr = rec_i.rs1_val + imm_s;
    assign k          = store_addr[1:0];
    assign fst_addr   = {store_addr[31:2], 2'b00};
    assign misaligned = is_sw && (k != 2'd0);

    assign fst_be    = 4'b1111 << k;
    assign fst_wdata = rec_i.rs2_val << {k, 3'b000};
    assign snd_be    = 4'b1111 >> (3'd4 - {1'b0, k});
    assign snd_wdata = rec_i.rs2_val >> (6'd32 - {1'b0, k, 3'b000});

    // no pop while the second granule is pending.
    assign pop_o = !empty_i && !snd_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            snd_q          <= 1'b0;
            wx_en_o        <= 1'b0;
            mem_write_o    <= 1'b0;
            mem_snd_gran_o <= 1'b0;
            check_valid_o  <= 1'b0;
            mismatch_o     <= 1'b0;
            int_err_o      <= 1'b0;
        end else if (snd_q) begin
            snd_q          <= 1'b0;
            wx_en_o        <= 1'b0;
            mem_write_o    <= 1'b1;
            mem_snd_gran_o <= 1'b1;
            check_valid_o  <= 1'b1;  // the record ends with its second granule.
            mismatch_o     <= snd_mismatch_q;
            int_err_o      <= 1'b0;
        end else if (pop_o) begin
            snd_q          <= misaligned;
            wx_en_o        <= spec_we;
            mem_write_o    <= is_sw;
            mem_snd_gran_o <= 1'b0;
            check_valid_o  <= !misaligned;
            mismatch_o     <= is_sw ? (rec_i.rd_we && !misaligned) : (supported && reg_mismatch);
            int_err_o      <= !supported;
        end else begin
            wx_en_o        <= 1'b0;
            mem_write_o    <= 1'b0;
            mem_snd_gran_o <= 1'b0;
            check_valid_o  <= 1'b0;
            mismatch_o     <= 1'b0;
            int_err_o      <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (snd_q) begin
            mem_addr_o  <= snd_addr_q;
            mem_wdata_o <= snd_wdata_q;
            mem_be_o    <= snd_be_q;
        end else if (pop_o) begin
            wx_addr_o      <= rd;
            wx_o           <= spec_wdata;
            mem_addr_o     <= fst_addr;
            mem_wdata_o    <= fst_wdata;
            mem_be_o       <= fst_be;
            snd_addr_q     <= fst_addr + 32'd4;
            snd_wdata_q    <= snd_wdata;
            snd_be_q       <= snd_be;
            snd_mismatch_q <= rec_i.rd_we;  // a store never writes rd.
        end
    end

endmodule

//--- test/spec_check_properties.sv
// Concurrent checks on the retirement checker, bound into spec_check_top.
// A reference model captures each report from the retire inputs, tracks FIFO
// occupancy and queues the expected results, which the assertions compare.

`include "spec_check_macros.svh"

module spec_check_properties (
    input logic        clk_i,
    input logic        rst_i,
    input logic        retire_valid_i,
    input logic [31:0] retire_insn_i,
    input logic [31:0] retire_rs1_i,
    input logic [31:0] retire_rs2_i,
    input logic [31:0] retire_rd_wdata_i,
    input logic        retire_rd_we_i,
    input logic        step_pop_i,
    input logic        wx_en_i,
    input logic [4:0]  wx_addr_i,
    input logic [31:0] wx_i,
    input logic        mem_write_i,
    input logic [31:0] mem_addr_i,
    input logic [31:0] mem_wdata_i,
    input logic [3:0]  mem_be_i,
    input logic        mem_snd_gran_i,
    input logic        check_valid_i,
    input logic        mismatch_i,
    input logic        int_err_i,
    input logic        overflow_i
);

    typedef struct packed {
        logic        wr;
        logic [4:0]  rd;
        logic [31:0] wx;
        logic        st;
        logic        mis;
        logic [31:0] a1;
        logic [31:0] d1;
        logic [3:0]  b1;
        logic [31:0] a2;
        logic [31:0] d2;
        logic [3:0]  b2;
        logic        mism;
        logic        ierr;
    } exp_t;

    int   err_cnt = 0;  // read by the testbench.
    exp_t exp_mem [16];
    exp_t cap_exp_q;
    exp_t h;
    logic cap_v_q;
    logic dropped_q;
    logic acc;
    int   count_q;
    int   head_q;
    int   tail_q;
    int   exp_cnt;

    function automatic exp_t expect_of(logic [31:0] insn, logic [31:0] rs1, logic [31:0] rs2,
                                       logic [31:0] wd, logic we);
        exp_t e;
        logic [31:0] a;
        e = '0;
        e.rd = insn[11:7];
        if (insn[6:0] == `SPEC_OP_IMM && insn[14:12] == `SPEC_F3_ADD) begin
            e.wx = rs1 + {{20{insn[31]}}, insn[31:20]};
        end else if (insn[6:0] == `SPEC_OP_REG && insn[14:12] == `SPEC_F3_ADD &&
                     insn[31:25] == 7'd0) begin
            e.wx = rs1 + rs2;
        end else if (insn[6:0] == `SPEC_OP_LUI) begin
            e.wx = {insn[31:12], 12'h000};
        end else if (insn[6:0] == `SPEC_OP_STORE && insn[14:12] == `SPEC_F3_SW) begin
            e.st = 1'b1;
        end else begin
            e.ierr = 1'b1;
        end
        e.wr = !e.st && !e.ierr && (e.rd != 5'd0);
        if (e.st) begin
            a = rs1 + {{20{insn[31]}}, insn[31:25], insn[11:7]};
            e.a1 = {a[31:2], 2'b00};
            e.a2 = e.a1 + 32'd4;
            e.mis = (a[1:0] != 2'b00);
            e.mism = we;
            case (a[1:0])
                2'd0: begin e.b1 = 4'b1111; e.d1 = rs2; end
                2'd1: begin e.b1 = 4'b1110; e.d1 = {rs2[23:0], 8'h00};
                      e.b2 = 4'b0001; e.d2 = {24'h0, rs2[31:24]}; end
                2'd2: begin e.b1 = 4'b1100; e.d1 = {rs2[15:0], 16'h0};
                      e.b2 = 4'b0011; e.d2 = {16'h0, rs2[31:16]}; end
                default: begin e.b1 = 4'b1000; e.d1 = {rs2[7:0], 24'h0};
                      e.b2 = 4'b0111; e.d2 = {8'h0, rs2[31:8]}; end
            endcase
        end else if (!e.ierr) begin
            e.mism = (we != e.wr) || (e.wr && wd != e.wx);
        end
        return e;
    endfunction

    assign acc     = cap_v_q && (count_q < `SPEC_FIFO_DEPTH || step_pop_i);
    assign exp_cnt = tail_q - head_q;
    assign h       = exp_mem[head_q % 16];

    always @(posedge clk_i) begin
        if (rst_i) begin
            cap_v_q   <= 1'b0;
            dropped_q <= 1'b0;
            count_q   <= 0;
            head_q    <= 0;
            tail_q    <= 0;
        end else begin
            cap_v_q <= retire_valid_i;
            if (retire_valid_i) begin
                cap_exp_q <= expect_of(retire_insn_i, retire_rs1_i, retire_rs2_i,
                                       retire_rd_wdata_i, retire_rd_we_i);
            end
            dropped_q <= cap_v_q && !acc;  // a full FIFO loses this record.
            if (acc) begin
                exp_mem[tail_q % 16] <= cap_exp_q;
                tail_q <= tail_q + 1;
            end
            count_q <= count_q + int'(acc) - int'(step_pop_i);
            if (check_valid_i) head_q <= head_q + 1;
        end
    end

    a_reset_low: assert property (@(posedge clk_i) $fell(rst_i) |->
        !(check_valid_i || wx_en_i || mem_write_i || mismatch_i || int_err_i || overflow_i))
        else begin err_cnt++; $error("Fail %0t: control output high after reset", $time); end

    a_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        retire_valid_i && exp_cnt == 0 && !cap_v_q |-> ##3 (check_valid_i || mem_write_i))
        else begin err_cnt++; $error("Fail %0t: isolated record not done in 3 cycles", $time); end

    a_result: assert property (@(posedge clk_i) disable iff (rst_i)
        check_valid_i |-> exp_cnt != 0 && int_err_i == h.ierr && wx_en_i == h.wr &&
        (!h.wr || (wx_addr_i == h.rd && wx_i == h.wx)) && mismatch_i == h.mism &&
        mem_write_i == h.st)
        else begin err_cnt++; $error("Fail %0t: wrong result for record", $time); end

    a_last_gran: assert property (@(posedge clk_i) disable iff (rst_i)
        check_valid_i && mem_write_i |-> (h.mis ?
        (mem_snd_gran_i && mem_addr_i == h.a2 && mem_be_i == h.b2 && mem_wdata_i == h.d2) :
        (!mem_snd_gran_i && mem_addr_i == h.a1 && mem_be_i == h.b1 && mem_wdata_i == h.d1)))
        else begin err_cnt++; $error("Fail %0t: wrong final store granule", $time); end

    a_first_gran: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_write_i && !check_valid_i |-> exp_cnt != 0 && h.mis && !mem_snd_gran_i &&
        mem_addr_i == h.a1 && mem_be_i == h.b1 && mem_wdata_i == h.d1 && !wx_en_i)
        else begin err_cnt++; $error("Fail %0t: wrong first store granule", $time); end

    a_second_follows: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_write_i && !check_valid_i |=> check_valid_i && mem_snd_gran_i)
        else begin err_cnt++; $error("Fail %0t: second granule missing", $time); end

    a_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
        overflow_i == dropped_q)
        else begin err_cnt++; $error("Fail %0t: overflow_o disagrees with model", $time); end

endmodule

bind spec_check_top spec_check_properties i_props (
    .clk_i, .rst_i, .retire_valid_i, .retire_insn_i, .retire_rs1_i, .retire_rs2_i,
    .retire_rd_wdata_i, .retire_rd_we_i,
    .step_pop_i     (step_pop),
    .wx_en_i        (wx_en_o),
    .wx_addr_i      (wx_addr_o),
    .wx_i           (wx_o),
    .mem_write_i    (mem_write_o),
    .mem_addr_i     (mem_addr_o),
    .mem_wdata_i    (mem_wdata_o),
    .mem_be_i       (mem_be_o),
    .mem_snd_gran_i (mem_snd_gran_o),
    .check_valid_i  (check_valid_o),
    .mismatch_i     (mismatch_o),
    .int_err_i      (int_err_o),
    .overflow_i     (overflow_o)
);

//--- test/spec_check_tb.sv
// Testbench for the retirement checker.
// Drives retire reports into the DUT; the bound properties do the checking.

`include "spec_check_macros.svh"

module spec_check_tb;

    logic        clk_i, rst_i, retire_valid_i, retire_rd_we_i;
    logic [31:0] retire_insn_i, retire_pc_i, retire_rs1_i, retire_rs2_i, retire_rd_wdata_i;
    logic        wx_en_o, mem_write_o, mem_snd_gran_o, check_valid_o;
    logic        mismatch_o, int_err_o, overflow_o;
    logic [4:0]  wx_addr_o;
    logic [31:0] wx_o, mem_addr_o, mem_wdata_o;
    logic [3:0]  mem_be_o;
    logic [31:0] lfsr = 32'h0d35_0a02;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          err_before;
    logic        timed_out = 1'b0;

    spec_check_top i_spec_check_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // galois LFSR step for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    task automatic send(logic [31:0] insn, logic [31:0] rs1, logic [31:0] rs2,
                        logic [31:0] wd, logic we);
        @(posedge clk_i);
        #1;
        retire_valid_i    = 1'b1;
        retire_insn_i     = insn;
        retire_pc_i       = rand_bits(30) << 2;
        retire_rs1_i      = rs1;
        retire_rs2_i      = rs2;
        retire_rd_wdata_i = wd;
        retire_rd_we_i    = we;
    endtask

    task automatic go_idle();
        @(posedge clk_i);
        #1 retire_valid_i = 1'b0;
    endtask

    // waits until the bound model has no record left in flight.
    task automatic drain(string name);
        int t;
        t = 0;
        while ((i_spec_check_top.i_props.exp_cnt != 0 || i_spec_check_top.i_props.cap_v_q)
               && !timed_out) begin
            @(negedge clk_i);
            t++;
            if (t > 300) begin
                $display("timeout: records of test %s never finished", name);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic finish_test(string name);
        drain(name);
        if (i_spec_check_top.i_props.err_cnt == err_before && !timed_out) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: FAILED", name);
        end
        err_before = i_spec_check_top.i_props.err_cnt;
    endtask

    task automatic store(logic [1:0] k, logic we);
        logic [11:0] imm;
        imm = {10'(rand_bits(10)), 2'b00};
        send({imm[11:5], 5'(rand_bits(5)), 5'(rand_bits(5)), `SPEC_F3_SW, imm[4:0],
              `SPEC_OP_STORE},
             {30'(rand_bits(30)), k}, rand_bits(32), rand_bits(32), we);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        logic [4:0]  rd;
        retire_valid_i = 1'b0;
        retire_insn_i = '0;
        retire_pc_i = '0;
        retire_rs1_i = '0;
        retire_rs2_i = '0;
        retire_rd_wdata_i = '0;
        retire_rd_we_i = 1'b0;
        rst_i = 1'b1;
        repeat (16) @(posedge clk_i);
        #1 rst_i = 1'b0;
        err_before = i_spec_check_top.i_props.err_cnt;

        a = rand_bits(32);
        b = rand_bits(32);
        imm = 12'(rand_bits(12));
        rd = {4'(rand_bits(4)), 1'b1};
        send({imm, 5'd1, `SPEC_F3_ADD, rd, `SPEC_OP_IMM}, a, b, a + {{20{imm[11]}}, imm}, 1'b1);
        go_idle();
        drain("addi");
        send({7'd0, 5'd2, 5'd1, `SPEC_F3_ADD, rd, `SPEC_OP_REG}, a, b, a + b, 1'b1);
        go_idle();
        drain("add");
        send({b[31:12], rd, `SPEC_OP_LUI}, a, b, {b[31:12], 12'h000}, 1'b1);
        go_idle();
        finish_test("alu results");

        send({imm, 5'd1, `SPEC_F3_ADD, 5'd0, `SPEC_OP_IMM}, a, b, 32'd0, 1'b0);
        send({imm, 5'd1, `SPEC_F3_ADD, rd, `SPEC_OP_IMM}, a, b, ~(a + {{20{imm[11]}}, imm}), 1'b1);
        send({7'd0, 5'd2, 5'd1, `SPEC_F3_ADD, rd, `SPEC_OP_REG}, a, b, a + b, 1'b0);
        go_idle();
        finish_test("x0 and claims");

        // every offset once without and once with a claimed register write.
        for (int k = 0; k < 8; k++) begin
            store(k[1:0], k[2]);
            go_idle();
            drain("store");
        end
        finish_test("stores");

        send({25'(rand_bits(25)), 7'b0000011}, a, b, a, 1'b1);  // a load, outside the subset.
        go_idle();
        finish_test("unsupported");

        for (int i = 0; i < `SPEC_FIFO_DEPTH + 6; i++) begin
            store(2'(i % 3 + 1), 1'b0);
        end
        go_idle();
        finish_test("burst");

        $display("summary: %0d passed, %0d failed, %0d assertion errors", pass_cnt, fail_cnt,
                 i_spec_check_top.i_props.err_cnt);
        if (fail_cnt == 0 && !timed_out && i_spec_check_top.i_props.err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
